// File: source/sdmacPkg.sv
`default_nettype none

package sdmacPkg;

    // Word FIFO geometry
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = 3;
    // Occupancy and credit counters must hold FIFO_DEPTH itself
    localparam int CNT_W = PTR_W + 1;

    // One lane per byte of the host word
    localparam int LANES = 4;
    localparam int BYTE_W = 8;
    localparam int WORD_W = LANES * BYTE_W;

    // Credits the host grants for read-direction words after reset
    localparam int HOST_CREDITS = 4;

    // Flops between the chip's DREQ pin and the state machine
    localparam int SYNC_STAGES = 2;

    // Byte cycle of the SCSI sequencer
    // STROBE and LATCH hold DACK and RE/WE low, RELEASE returns them high
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        STROBE  = 2'd1,
        LATCH   = 2'd2,
        RELEASE = 2'd3
    } seqState_t;

    // Transfer direction, fixed while the data path is busy
    typedef enum logic {
        MEM_TO_SCSI = 1'b0,
        SCSI_TO_MEM = 1'b1
    } dmaDir_t;

endpackage

`default_nettype wire

// File: source/laneBusIf.sv
`timescale 1ns/10ps
`default_nettype none

interface laneBusIf import sdmacPkg::*; ();

    // Write group
    // Enables and data come from whichever side fills in the current direction
    wire  [LANES-1:0]  laneWe;
    logic [PTR_W-1:0]  wrIdx;
    wire  [WORD_W-1:0] wrData;

    // Read group, each lane drives its own byte of rdData
    logic [PTR_W-1:0]  rdIdx;
    wire  [WORD_W-1:0] rdData;

    // Clear group, driven by the draining side
    wire  [LANES-1:0]  laneClr;
    logic [PTR_W-1:0]  clrIdx;

    // Status between sequencer and host port
    logic fifoFull;
    logic fifoEmpty;
    logic incWordIn;
    logic incWordOut;

    modport filler  (output laneWe, wrIdx, wrData);
    modport drainer (output rdIdx, laneClr, clrIdx, input rdData);
    modport lane    (input laneWe, wrIdx, wrData, rdIdx, laneClr, clrIdx,
                     output rdData);

    // Word pointer handshake
    modport seq  (output incWordIn, incWordOut, input fifoFull, fifoEmpty);
    modport port (input incWordIn, incWordOut, output fifoFull, fifoEmpty);

endinterface

`default_nettype wire

// File: source/byteLane.sv
`timescale 1ns/10ps
`default_nettype none

module byteLane import sdmacPkg::*; #(
    parameter int LANE_IDX = 0
) (
    input wire     BCLK,
    input wire     CRESET_,
    laneBusIf.lane lane
);

    // One byte per word entry
    logic [BYTE_W-1:0]     entry [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] entryValid;

    logic              weHit;
    logic              clrHit;
    logic [BYTE_W-1:0] wrByte;

    // This lane's slice of the shared buses
    assign weHit  = lane.laneWe[LANE_IDX];
    assign clrHit = lane.laneClr[LANE_IDX];
    assign wrByte = lane.wrData[BYTE_W*LANE_IDX +: BYTE_W];

    // Valid bits track which entries hold a written byte
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            entryValid <= '0;
        end else begin
            if (clrHit) begin
                entryValid[lane.clrIdx] <= 1'b0;
            end
            // A write to the same entry wins over a clear
            if (weHit) begin
                entryValid[lane.wrIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (weHit) begin
            entry[lane.wrIdx] <= wrByte;
        end
    end

    // Unwritten bytes read as zero
    // gives the zero fill of a flushed partial word
    assign lane.rdData[BYTE_W*LANE_IDX +: BYTE_W] =
        entryValid[lane.rdIdx] ? entry[lane.rdIdx] : '0;

endmodule

`default_nettype wire

// File: source/scsiSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module scsiSequencer import sdmacPkg::*; (
    input  wire               BCLK,
    input  wire               CRESET_,
    input  var dmaDir_t       dmaDir_i,
    // SCSI controller chip
    input  wire               scsiDreqN_i,
    input  wire  [BYTE_W-1:0] scsiData_i,
    output logic [BYTE_W-1:0] scsiData_o,
    output logic              scsiDackN_o,
    output logic              scsiReN_o,
    output logic              scsiWeN_o,
    // Partial word commit
    input  wire               flush_i,
    output logic              busy_o,
    // Lane access and word handshake
    laneBusIf.filler          fill,
    laneBusIf.drainer         drain,
    laneBusIf.seq             st
);

    logic [SYNC_STAGES-1:0] dreqSync;
    seqState_t              state;
    seqState_t              nextState;
    logic [1:0]             bytePtr;
    logic [LANES-1:0]       ptrLane;

    logic isRead;
    logic reqSeen;
    logic roomOk;
    logic flushHit;
    logic byteDone;
    logic wordDone;
    logic strobeNext;

    assign isRead = (dmaDir_i == SCSI_TO_MEM);

    // DREQ is asynchronous to BCLK
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dreqSync <= '1;
        end else begin
            dreqSync <= {dreqSync[SYNC_STAGES-2:0], scsiDreqN_i};
        end
    end

    assign reqSeen = ~dreqSync[SYNC_STAGES-1];

    // Read needs a free entry, write needs a stored word
    assign roomOk = isRead ? ~st.fifoFull : ~st.fifoEmpty;

    // Flush only counts between bytes and only with bytes pending
    assign flushHit = flush_i && isRead && (state == IDLE) && (bytePtr != 2'd0);

    // Byte moves on the edge that ends LATCH
    assign byteDone = (state == LATCH);
    assign wordDone = (byteDone && (bytePtr == 2'd3)) || flushHit;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                // Back-pressure keeps us here
                if (reqSeen && roomOk && !flushHit) begin
                    nextState = STROBE;
                end
            end
            STROBE:  nextState = LATCH;
            LATCH:   nextState = RELEASE;
            RELEASE: nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    // Strobes are low in exactly STROBE and LATCH
    assign strobeNext = (nextState == STROBE) || (nextState == LATCH);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state       <= IDLE;
            bytePtr     <= 2'd0;
            scsiDackN_o <= 1'b1;
            scsiReN_o   <= 1'b1;
            scsiWeN_o   <= 1'b1;
        end else begin
            state <= nextState;
            // Registered so the pins change cleanly on the clock edge
            scsiDackN_o <= ~strobeNext;
            scsiReN_o   <= ~(strobeNext && isRead);
            scsiWeN_o   <= ~(strobeNext && !isRead);
            // Pointer wraps to 0 on a full word or a flush
            if (wordDone) begin
                bytePtr <= 2'd0;
            end else if (byteDone) begin
                bytePtr <= bytePtr + 2'd1;
            end
        end
    end

    // One-hot lane select from the byte pointer
    assign ptrLane = {{(LANES-1){1'b0}}, 1'b1} << bytePtr;

    // SCSI to memory: write the chip byte into the current lane
    // Released to the host port in the other direction
    assign fill.laneWe = isRead ? (byteDone ? ptrLane : '0) : 'z;
    assign fill.wrData = isRead ? {LANES{scsiData_i}} : 'z;

    // Memory to SCSI: present the lane byte, free it once sent
    assign scsiData_o    = drain.rdData[BYTE_W*bytePtr +: BYTE_W];
    assign drain.laneClr = isRead ? 'z : (byteDone ? ptrLane : '0);

    // Word pointer steps go to the host port
    assign st.incWordIn  = wordDone && isRead;
    assign st.incWordOut = wordDone && !isRead;

    assign busy_o = (state != IDLE) || (bytePtr != 2'd0);

endmodule

`default_nettype wire

// File: source/hostWordPort.sv
`timescale 1ns/10ps
`default_nettype none

module hostWordPort import sdmacPkg::*; (
    input  wire               BCLK,
    input  wire               CRESET_,
    input  var dmaDir_t       dmaDir_i,
    // Read direction, words out under host credits
    output logic              wordValid_o,
    output logic [WORD_W-1:0] wordData_o,
    input  wire               creditReturn_i,
    // Write direction, words in from the host
    input  wire               hostValid_i,
    input  wire  [WORD_W-1:0] hostData_i,
    output logic              creditGrant_o,
    // Lane access and word handshake
    laneBusIf.filler          fill,
    laneBusIf.drainer         drain,
    laneBusIf.port            st
);

    logic [PTR_W-1:0] inPtr;
    logic [PTR_W-1:0] outPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;

    logic isRead;
    logic hostPop;
    logic pushWord;
    logic popWord;

    assign isRead = (dmaDir_i == SCSI_TO_MEM);

    // Drain one whole word per cycle while data and credit both exist
    assign hostPop = isRead && (count != '0) && (credits != '0);

    // Who fills and who drains swaps with the direction
    assign pushWord = isRead ? st.incWordIn : hostValid_i;
    assign popWord  = isRead ? hostPop : st.incWordOut;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            inPtr         <= '0;
            outPtr        <= '0;
            count         <= '0;
            credits       <= CNT_W'(HOST_CREDITS);
            wordValid_o   <= 1'b0;
            creditGrant_o <= 1'b0;
        end else begin
            // Pointers wrap naturally at FIFO_DEPTH
            if (pushWord) begin
                inPtr <= inPtr + 1'b1;
            end
            if (popWord) begin
                outPtr <= outPtr + 1'b1;
            end
            // Push and pop can land on the same edge
            count <= count + CNT_W'(pushWord) - CNT_W'(popWord);
            // One credit per emitted word, one back per return pulse
            credits <= credits + CNT_W'(creditReturn_i && isRead) - CNT_W'(hostPop);
            wordValid_o <= hostPop;
            // Each word the sequencer sends frees a host slot
            creditGrant_o <= st.incWordOut && !isRead;
        end
    end

    // Word is captured from the lanes as it is cleared
    always_ff @(posedge BCLK) begin
        if (hostPop) begin
            wordData_o <= drain.rdData;
        end
    end

    // Indices for all lanes come from here in both directions
    assign fill.wrIdx   = inPtr;
    assign drain.rdIdx  = outPtr;
    assign drain.clrIdx = outPtr;

    // Memory to SCSI: host word goes into all four lanes at once
    assign fill.laneWe = isRead ? 'z : {LANES{hostValid_i}};
    assign fill.wrData = isRead ? 'z : hostData_i;

    // SCSI to memory: whole entry is freed when the word leaves
    assign drain.laneClr = isRead ? {LANES{hostPop}} : 'z;

    assign st.fifoFull  = (count == CNT_W'(FIFO_DEPTH));
    assign st.fifoEmpty = (count == '0);

endmodule

`default_nettype wire

// File: source/sdmacScsiTop.sv
`timescale 1ns/10ps
`default_nettype none

module sdmacScsiTop import sdmacPkg::*; (
    input  wire               BCLK,
    input  wire               CRESET_,
    input  var dmaDir_t       dmaDir_i,
    // SCSI controller chip
    input  wire               scsiDreqN_i,
    input  wire  [BYTE_W-1:0] scsiData_i,
    output logic [BYTE_W-1:0] scsiData_o,
    output logic              scsiDackN_o,
    output logic              scsiReN_o,
    output logic              scsiWeN_o,
    input  wire               flush_i,
    output logic              busy_o,
    // Host word side
    output logic              wordValid_o,
    output logic [WORD_W-1:0] wordData_o,
    input  wire               creditReturn_i,
    input  wire               hostValid_i,
    input  wire  [WORD_W-1:0] hostData_i,
    output logic              creditGrant_o
);

    // Shared lane buses and word handshake
    laneBusIf laneBus ();

    // Byte side, one SCSI byte per DACK
    scsiSequencer scsiSequencer_i (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dmaDir_i    (dmaDir_i),
        .scsiDreqN_i (scsiDreqN_i),
        .scsiData_i  (scsiData_i),
        .scsiData_o  (scsiData_o),
        .scsiDackN_o (scsiDackN_o),
        .scsiReN_o   (scsiReN_o),
        .scsiWeN_o   (scsiWeN_o),
        .flush_i     (flush_i),
        .busy_o      (busy_o),
        .fill        (laneBus.filler),
        .drain       (laneBus.drainer),
        .st          (laneBus.seq)
    );

    // Word side, owns the pointers and the occupancy count
    hostWordPort hostWordPort_i (
        .BCLK           (BCLK),
        .CRESET_        (CRESET_),
        .dmaDir_i       (dmaDir_i),
        .wordValid_o    (wordValid_o),
        .wordData_o     (wordData_o),
        .creditReturn_i (creditReturn_i),
        .hostValid_i    (hostValid_i),
        .hostData_i     (hostData_i),
        .creditGrant_o  (creditGrant_o),
        .fill           (laneBus.filler),
        .drain          (laneBus.drainer),
        .st             (laneBus.port)
    );

    // Lane k holds byte k of every word
    for (genvar laneIdx = 0; laneIdx < LANES; laneIdx++) begin : genLane
        byteLane #(
            .LANE_IDX (laneIdx)
        ) byteLane_i (
            .BCLK    (BCLK),
            .CRESET_ (CRESET_),
            .lane    (laneBus.lane)
        );
    end

endmodule

`default_nettype wire

// File: sim/sdmacScsiTests.svh
// Strobes inactive and host side quiet straight after reset
task automatic idleAfterReset();
    resetDut(SCSI_TO_MEM);
    repeat (4) begin
        stepCycle();
        compareValues(1, scsiDackN_o, "DACK after reset");
        compareValues(1, scsiReN_o, "RE after reset");
        compareValues(1, scsiWeN_o, "WE after reset");
        compareValues(0, wordValid_o, "wordValid after reset");
        compareValues(0, creditGrant_o, "creditGrant after reset");
        compareValues(0, busy_o, "busy after reset");
    end
endtask

// Eight words from 32 bytes with credits returned at once
task automatic packReadWords();
    int w;
    resetDut(SCSI_TO_MEM);
    creditsOpen = 1'b1;
    loadChip(32);
    while (wordsSeen.size() < 8) begin
        stepCycle();
    end
    // A byte started after DREQ dropped would show up here
    repeat (8) stepCycle();
    for (w = 0; w < 8; w++) begin
        compareValues(packedWord(4 * w, 4), wordsSeen[w], "packed read word");
    end
    compareValues(32, dackFalls, "DACK count for 32 bytes");
endtask

// Host holds its credits so the FIFO fills and the chip stalls
task automatic stallOnCredits();
    int w;
    resetDut(SCSI_TO_MEM);
    loadChip(64);
    while (wordsSeen.size() < HOST_CREDITS) begin
        stepCycle();
    end
    while (dackFalls < (FIFO_DEPTH + HOST_CREDITS) * LANES) begin
        stepCycle();
    end
    // Room for several more bytes if the stall leaked
    repeat (40) stepCycle();
    compareValues(HOST_CREDITS, wordsSeen.size(), "words sent without credit return");
    compareValues((FIFO_DEPTH + HOST_CREDITS) * LANES, dackFalls, "DACKs while stalled");
    creditsOpen = 1'b1;
    while (wordsSeen.size() < 16) begin
        stepCycle();
    end
    for (w = 0; w < 16; w++) begin
        compareValues(packedWord(4 * w, 4), wordsSeen[w], "word after credit stall");
    end
endtask

// Flush commits two leftover bytes with zero upper lanes
task automatic flushPartialWord();
    resetDut(SCSI_TO_MEM);
    creditsOpen = 1'b1;
    loadChip(6);
    while (dackRises < 6) begin
        stepCycle();
    end
    // RELEASE lasts one cycle and the sequencer idles after it
    stepCycle();
    compareValues(1, busy_o, "busy with partial word");
    compareValues(1, wordsSeen.size(), "full words before flush");
    flush_i = 1'b1;
    stepCycle();
    flush_i = 1'b0;
    compareValues(0, busy_o, "busy after flush");
    while (wordsSeen.size() < 2) begin
        stepCycle();
    end
    compareValues(packedWord(0, 4), wordsSeen[0], "first word");
    compareValues(packedWord(4, 2), wordsSeen[1], "flushed partial word");
endtask

// Six host words go out to the chip in lane order
task automatic sendWriteWords();
    logic [7:0]  b;
    logic [31:0] w;
    int i;
    int k;
    resetDut(MEM_TO_SCSI);
    for (i = 0; i < 6; i++) begin
        for (k = 0; k < LANES; k++) begin
            randomByte(b);
            w[8*k +: 8] = b;
        end
        hostWords.push_back(w);
    end
    loadChip(24);
    while (chipSeen.size() < 24 || grantCount < 6) begin
        stepCycle();
    end
    // Any extra grant pulse would be counted here
    repeat (8) stepCycle();
    for (i = 0; i < 24; i++) begin
        w = hostWords[i / 4];
        compareValues(w[8*(i%4) +: 8], chipSeen[i], "byte at chip");
    end
    compareValues(6, grantCount, "creditGrant pulses");
endtask

// File: sim/sdmacScsiTb.sv
`timescale 1ns/10ps
`default_nettype none

module sdmacScsiTb import sdmacPkg::*; ();

    // Bytes moved over all tests set the cycle limit
    localparam int TOTAL_BYTES = 32 + 64 + 6 + 24;
    localparam int CYCLE_LIMIT = 20 * TOTAL_BYTES * 6;

    logic              BCLK;
    logic              CRESET_;
    dmaDir_t           dmaDir_i;
    logic              scsiDreqN_i;
    logic [BYTE_W-1:0] scsiData_i;
    logic [BYTE_W-1:0] scsiData_o;
    logic              scsiDackN_o;
    logic              scsiReN_o;
    logic              scsiWeN_o;
    logic              flush_i;
    logic              busy_o;
    logic              wordValid_o;
    logic [WORD_W-1:0] wordData_o;
    logic              creditReturn_i;
    logic              hostValid_i;
    logic [WORD_W-1:0] hostData_i;
    logic              creditGrant_o;

    // SCSI chip model
    logic [7:0] chipSupply [$];
    logic [7:0] chipSeen [$];
    int         dackFalls;
    int         dackRises;
    logic       dackPrev;

    // Host model
    logic [31:0] wordsSeen [$];
    logic [31:0] hostWords [$];
    bit          creditsOpen;
    int          hostOwed;
    int          hostCredits;
    int          hostSendIdx;
    int          grantCount;

    logic [31:0] lfsrState;
    int          cycleCount;

    sdmacScsiTop sdmacScsiTop_i (
        .BCLK           (BCLK),
        .CRESET_        (CRESET_),
        .dmaDir_i       (dmaDir_i),
        .scsiDreqN_i    (scsiDreqN_i),
        .scsiData_i     (scsiData_i),
        .scsiData_o     (scsiData_o),
        .scsiDackN_o    (scsiDackN_o),
        .scsiReN_o      (scsiReN_o),
        .scsiWeN_o      (scsiWeN_o),
        .flush_i        (flush_i),
        .busy_o         (busy_o),
        .wordValid_o    (wordValid_o),
        .wordData_o     (wordData_o),
        .creditReturn_i (creditReturn_i),
        .hostValid_i    (hostValid_i),
        .hostData_i     (hostData_i),
        .creditGrant_o  (creditGrant_o)
    );

    // 8 ns clock
    initial begin
        BCLK = 1'b0;
        forever #4 BCLK = ~BCLK;
    end

    // Watchdog on total run length
    initial begin
        cycleCount = 0;
        forever begin
            @(posedge BCLK);
            cycleCount++;
            if (cycleCount >= CYCLE_LIMIT) begin
                $display("Run timed out after %0d cycles", cycleCount);
                $display("STATUS: FAIL");
                $fatal(1, "Timeout");
            end
        end
    end

    // Fibonacci form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic randomByte(output logic [7:0] b);
        int k;
        b = '0;
        for (k = 0; k < 8; k++) begin
            lfsrState = lfsrStep(lfsrState);
            b = {b[6:0], lfsrState[0]};
        end
    endtask

    // Expected word puts supplied byte k in lane k and zero in missing lanes
    function automatic logic [31:0] packedWord(input int first, input int count);
        logic [31:0] w;
        int k;
        w = '0;
        for (k = 0; k < count; k++) begin
            w[8*k +: 8] = chipSupply[first + k];
        end
        return w;
    endfunction

    task automatic compareValues(input logic [31:0] expected, input logic [31:0] actual,
                                 input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, expected %h, got %h",
                     $time, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // One clock with outputs observed and inputs driven 1 ns after the edge
    task automatic stepCycle();
        @(posedge BCLK);
        #1;
        // DACK falling edge starts a byte
        if (!scsiDackN_o && dackPrev) begin
            // RE strobes a read byte and WE a write byte
            if (dmaDir_i == SCSI_TO_MEM) begin
                compareValues(0, scsiReN_o, "RE with DACK in read direction");
                compareValues(1, scsiWeN_o, "WE with DACK in read direction");
            end else begin
                compareValues(1, scsiReN_o, "RE with DACK in write direction");
                compareValues(0, scsiWeN_o, "WE with DACK in write direction");
                chipSeen.push_back(scsiData_o);
            end
            dackFalls++;
            // Chip drops DREQ on the DACK of its last byte
            if (dackFalls >= chipSupply.size()) begin
                scsiDreqN_i = 1'b1;
            end
        end
        // Next byte goes on the bus when DACK rises
        if (scsiDackN_o && !dackPrev) begin
            compareValues(2'b11, {scsiReN_o, scsiWeN_o}, "RE and WE released with DACK");
            dackRises++;
            if (dackRises < chipSupply.size()) begin
                scsiData_i = chipSupply[dackRises];
            end
        end
        dackPrev = scsiDackN_o;
        // Read side host returns one credit per word when open
        creditReturn_i = 1'b0;
        if (wordValid_o) begin
            wordsSeen.push_back(wordData_o);
            hostOwed++;
        end
        if (creditsOpen && hostOwed > 0) begin
            creditReturn_i = 1'b1;
            hostOwed--;
        end
        // Write side host spends its own credits
        if (creditGrant_o) begin
            grantCount++;
            hostCredits++;
        end
        hostValid_i = 1'b0;
        if (hostSendIdx < hostWords.size() && hostCredits > 0) begin
            hostValid_i = 1'b1;
            hostData_i  = hostWords[hostSendIdx];
            hostSendIdx++;
            hostCredits--;
        end
    endtask

    task automatic resetDut(input dmaDir_t dir);
        CRESET_        = 1'b0;
        dmaDir_i       = dir;
        scsiDreqN_i    = 1'b1;
        scsiData_i     = '0;
        flush_i        = 1'b0;
        creditReturn_i = 1'b0;
        hostValid_i    = 1'b0;
        hostData_i     = '0;
        chipSupply.delete();
        chipSeen.delete();
        wordsSeen.delete();
        hostWords.delete();
        dackFalls   = 0;
        dackRises   = 0;
        dackPrev    = 1'b1;
        creditsOpen = 1'b0;
        hostOwed    = 0;
        hostCredits = FIFO_DEPTH;
        hostSendIdx = 0;
        grantCount  = 0;
        repeat (16) stepCycle();
        CRESET_ = 1'b1;
        stepCycle();
    endtask

    // Chip gets n bytes ready and raises its request
    task automatic loadChip(input int n);
        logic [7:0] b;
        int k;
        for (k = 0; k < n; k++) begin
            randomByte(b);
            chipSupply.push_back(b);
        end
        scsiData_i  = chipSupply[0];
        scsiDreqN_i = 1'b0;
    endtask

    `include "sdmacScsiTests.svh"

    initial begin
        lfsrState = 32'd84721;
        idleAfterReset();
        packReadWords();
        stallOnCredits();
        flushPartialWord();
        sendWriteWords();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sdmacScsi.f
+incdir+sim
source/sdmacPkg.sv
source/laneBusIf.sv
source/byteLane.sv
source/scsiSequencer.sv
source/hostWordPort.sv
source/sdmacScsiTop.sv
sim/sdmacScsiTb.sv

// File: Makefile
# Verilator build and run of the SCSI DMA data path testbench

VERILATOR ?= verilator
TOP       ?= sdmacScsiTb
FILELIST  ?= sdmacScsi.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
